//--- all.f
logic/lcdMenuPkg.sv
logic/menuSequencer.sv
logic/screenCopier.sv
logic/charEditor.sv
logic/lcdMenuTop.sv
dv/lcdMenuTop_assert.sv
dv/lcdMenuTb.sv

//--- dv/lcdMenuTb.sv
`timescale 1ns/100ps

module lcdMenuTb;
	import lcdMenuPkg::*;

	localparam int clkPeriod = 8;
	localparam int lineLength = 16;
	localparam int cells = 2 * lineLength;
	// Twice the longest expected run, about 200 us
	localparam int runCycles = 12500;
	localparam int timeoutNs = 2 * runCycles * clkPeriod;
	// One render is two copies of about 33 cycles each
	localparam int screenTimeout = 200;

	// Step codes for the editor, even codes turn left
	localparam int stepPosLeft = 0;
	localparam int stepPosRight = 1;
	localparam int stepRowLeft = 2;
	localparam int stepRowRight = 3;
	localparam int stepColLeft = 4;
	localparam int stepColRight = 5;

	typedef logic [31:0][7:0] screenVec_t;

	// Editor position and character
	typedef struct packed {
		logic [4:0] pos;
		logic [3:0] col;
		logic [3:0] row;
	} editState_t;

	logic clk;
	logic reset;
	userInput_t userIn;
	charCode_t ramRdData;
	lcdWrite_t lcd;
	ramPort_t ram;

	// RAM model and shadow LCD
	charCode_t localRam [0:31];
	charCode_t shadowLcd [0:31];
	int lastCellWrites;
	int writeCount;
	int clearCount;

	// Expected values
	screenVec_t expScreen;
	charCode_t expLocal [0:31];
	lcdAddr_t expWrAddr;
	charCode_t expWrChar;
	int expWrites;
	int expClears;
	editState_t ed;
	integer seed;

	event doCompare;
	event compareDone;

	lcdMenuTop #(
		.lineLength(lineLength)
	) i_dut (
		.clk(clk),
		.reset(reset),
		.userIn(userIn),
		.ramRdData(ramRdData),
		.lcd(lcd),
		.ram(ram)
	);

	bind lcdMenuTop lcdMenuAssert i_assert (
		.clk(clk),
		.reset(reset),
		.lcd(lcd),
		.ram(ram)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clkPeriod / 2) clk = ~clk;
	end

	//////////////////////////////
	// Reference functions
	//////////////////////////////

	// Left is next on the ring, confirm screen toggles
	function automatic menuText_t ringStep(input menuText_t opt, input logic left);
		menuText_t n;
		case (opt)
			optDisplayLocal: n = left ? optModifyLocal : optClearLocal;
			optModifyLocal: n = left ? optClearLocal : optDisplayLocal;
			optClearLocal: n = left ? optDisplayLocal : optModifyLocal;
			optYes: n = optNo;
			default: n = optYes;
		endcase
		return n;
	endfunction

	// Menu text cell i of screen k holds k*32+i
	function automatic screenVec_t expectScreen(input logic showLocal, input menuText_t opt);
		screenVec_t s;
		menuText_t title;
		title = (opt == optYes || opt == optNo) ? titleAreYouSure : titleMain;
		for (int i = 0; i < cells; i++)
		begin
			if (showLocal)
				s[i] = expLocal[i];
			else if (i < lineLength)
				s[i] = charCode_t'(32 * title + i);
			else
				s[i] = charCode_t'(32 * opt + i - lineLength);
		end
		return s;
	endfunction

	// Columns skip 0-1 and 8-9
	function automatic editState_t expectChar(input editState_t s, input int step);
		editState_t n;
		n = s;
		case (step)
			stepPosLeft: n.pos = s.pos + 5'd1;
			stepPosRight: n.pos = s.pos - 5'd1;
			stepRowLeft: n.row = s.row + 4'd1;
			stepRowRight: n.row = s.row - 4'd1;
			stepColLeft: n.col = (s.col == 4'd2) ? 4'd15 : (s.col == 4'd10) ? 4'd7 : s.col - 4'd1;
			stepColRight: n.col = (s.col == 4'd7) ? 4'd10 : (s.col == 4'd15) ? 4'd2 : s.col + 4'd1;
			default: n = s;
		endcase
		return n;
	endfunction

	//////////////////////////////
	// Checking
	//////////////////////////////

	task automatic abortRun(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("ERROR %s got 0x%h expected 0x%h", name, got, exp);
			abortRun("Mismatch between DUT and expected value");
		end
	endtask

	// Combinational RAM reads
	assign ramRdData = (ram.sel == selLocal) ? localRam[ram.addr]
		: charCode_t'(32 * ram.menuSelect + ram.addr);

	// Shadow LCD, RAM model and write checks
	always @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < cells; i++)
			begin
				localRam[i] <= 8'h40 + i;
				shadowLcd[i] <= 8'h00;
			end
			lastCellWrites <= 0;
			writeCount <= 0;
			clearCount <= 0;
		end
		else
		begin
			if (lcd.write === 1'b1)
			begin
				shadowLcd[lcd.addr] <= lcd.data;
				if (lcd.addr == lcdAddr_t'(cells - 1))
					lastCellWrites <= lastCellWrites + 1;
			end
			if (ram.write === 1'b1)
			begin
				checkValue("ram.sel", ram.sel, selLocal);
				checkValue("ram.addr", ram.addr, expWrAddr);
				checkValue("ram.wrData", ram.wrData, expWrChar);
				localRam[ram.addr] <= ram.wrData;
				writeCount <= writeCount + 1;
			end
			if (ram.clear === 1'b1)
			begin
				for (int i = 0; i < cells; i++)
					localRam[i] <= 8'h00;
				clearCount <= clearCount + 1;
			end
		end
	end

	// Bound checker failures end the run too
	always @(posedge clk)
		if (i_dut.i_assert.failCount != 0)
			abortRun("An assertion in the bound checker failed");

	// Screen, RAM contents and strobe counts
	initial
	begin
		forever
		begin
			@(doCompare);
			for (int i = 0; i < cells; i++)
				checkValue($sformatf("lcd.data[%0d]", i), shadowLcd[i], expScreen[i]);
			for (int i = 0; i < cells; i++)
				checkValue($sformatf("localRam[%0d]", i), localRam[i], expLocal[i]);
			checkValue("ram.write count", writeCount, expWrites);
			checkValue("ram.clear count", clearCount, expClears);
			-> compareDone;
		end
	end

	task automatic compareState();
		-> doCompare;
		@(compareDone);
	endtask

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	task automatic idle(input int n);
		repeat (n)
		begin
			@(posedge clk);
			#1;
		end
	endtask

	// One cycle pulse, called 1 ns after an edge
	task automatic pulse(input userInput_t v);
		userIn = v;
		@(posedge clk);
		#1;
		userIn = '0;
	endtask

	task automatic rotate(input logic left);
		userInput_t v;
		v = '0;
		v.rotaryEvent = 1'b1;
		v.rotaryLeft = left;
		pulse(v);
	endtask

	task automatic pressKnob();
		userInput_t v;
		v = '0;
		v.rotaryBtn = 1'b1;
		pulse(v);
	endtask

	task automatic pressMenu();
		userInput_t v;
		v = '0;
		v.menuBtn = 1'b1;
		pulse(v);
	endtask

	task automatic applyStep(input int step);
		userInput_t v;
		v = '0;
		case (step)
			stepColLeft: v.colLeftBtn = 1'b1;
			stepColRight: v.colRightBtn = 1'b1;
			default:
			begin
				v.rotaryEvent = 1'b1;
				v.rotaryLeft = (step % 2 == 0);
			end
		endcase
		pulse(v);
		ed = expectChar(ed, step);
	endtask

	// One character step, then the echo on the current cell
	task automatic stepWithEcho(input int step);
		applyStep(step);
		idle(2);
		expScreen[ed.pos] = {ed.col, ed.row};
		compareState();
	endtask

	// Wait for the write to the last cell, then let the handshake finish
	task automatic waitScreen();
		int start;
		int waited;
		start = lastCellWrites;
		waited = 0;
		while (lastCellWrites == start)
		begin
			if (waited == screenTimeout)
				abortRun("No complete screen was drawn in time");
			idle(1);
			waited++;
		end
		idle(3);
	endtask

	task automatic expectMenu(input menuText_t opt);
		waitScreen();
		expScreen = expectScreen(1'b0, opt);
		compareState();
	endtask

	task automatic expectLocal();
		waitScreen();
		expScreen = expectScreen(1'b1, optDisplayLocal);
		compareState();
	endtask

	//////////////////////////////
	// Test sequence
	//////////////////////////////

	initial
	begin
		logic [31:0] rnd;
		menuText_t opt;
		int steps;
		seed = 32'h0f261000;
		userIn = '0;
		reset = 1'b1;
		expWrAddr = '0;
		expWrChar = '0;
		expWrites = 0;
		expClears = 0;
		for (int i = 0; i < cells; i++)
			expLocal[i] = 8'h40 + i;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;

		// Reset screen
		opt = optDisplayLocal;
		expectMenu(opt);

		// Menu ring
		repeat (8)
		begin
			rnd = $random(seed);
			rotate(rnd[0]);
			opt = ringStep(opt, rnd[0]);
			expectMenu(opt);
		end
		pressMenu();
		opt = optDisplayLocal;
		expectMenu(opt);

		// Display local RAM and back
		pressKnob();
		expectLocal();
		pressKnob();
		expectMenu(opt);

		// Modify local RAM
		rotate(1'b1);
		opt = ringStep(opt, 1'b1);
		expectMenu(opt);
		pressKnob();
		expectLocal();
		ed.pos = '0;
		ed.col = defaultChar[7:4];
		ed.row = defaultChar[3:0];
		repeat (2)
		begin
			rnd = $random(seed);
			steps = 1 + int'(rnd[2:0]);
			repeat (steps)
			begin
				rnd = $random(seed);
				applyStep(rnd[0] ? stepPosLeft : stepPosRight);
				idle(1);
			end
			// Into character select
			pressKnob();
			idle(1);
			rnd = $random(seed);
			steps = 1 + int'(rnd[2:0]);
			repeat (steps)
			begin
				rnd = $random(seed);
				stepWithEcho(stepRowLeft + int'(rnd[1:0]));
			end
			// A full turn each way passes every column wrap
			repeat (12)
				stepWithEcho(stepColLeft);
			repeat (12)
				stepWithEcho(stepColRight);
			expWrAddr = ed.pos;
			expWrChar = {ed.col, ed.row};
			expWrites++;
			expLocal[ed.pos] = {ed.col, ed.row};
			pressKnob();
			idle(3);
			compareState();
		end
		pressMenu();
		opt = optDisplayLocal;
		expectMenu(opt);

		// Clear, answer no
		rotate(1'b0);
		opt = ringStep(opt, 1'b0);
		expectMenu(opt);
		pressKnob();
		opt = optYes;
		expectMenu(opt);
		rotate(1'b1);
		opt = ringStep(opt, 1'b1);
		expectMenu(opt);
		pressKnob();
		opt = optDisplayLocal;
		expectMenu(opt);

		// Clear, answer yes
		rotate(1'b0);
		opt = ringStep(opt, 1'b0);
		expectMenu(opt);
		pressKnob();
		opt = optYes;
		expectMenu(opt);
		pressKnob();
		expClears++;
		for (int i = 0; i < cells; i++)
			expLocal[i] = 8'h00;
		opt = optDisplayLocal;
		expectMenu(opt);

		// Cleared RAM shows as zeros
		pressKnob();
		expectLocal();
		pressKnob();
		expectMenu(opt);

		if (i_dut.i_assert.failCount != 0)
			abortRun("An assertion in the bound checker failed");
		else
		begin
			$display("** PASS **");
			$finish;
		end
	end

	// Watchdog
	initial
	begin
		#(timeoutNs);
		abortRun("Watchdog expired before the test finished");
	end

endmodule

//--- dv/lcdMenuTop_assert.sv
`timescale 1ns/100ps

module lcdMenuAssert (
	input logic clk,
	input logic reset,
	input lcdMenuPkg::lcdWrite_t lcd,
	input lcdMenuPkg::ramPort_t ram
);
	import lcdMenuPkg::*;

	// Failed assertions so far
	int failCount = 0;

	// Echo and RAM commit are never in the same cycle
	lcdRamExclusive: assert property (@(posedge clk) disable iff (reset)
		!(lcd.write && ram.write))
		else
		begin
			failCount++;
			$error("LCD write and RAM write in the same cycle");
		end

	// Clear is a single pulse
	clearPulse: assert property (@(posedge clk) disable iff (reset)
		ram.clear |=> !ram.clear)
		else
		begin
			failCount++;
			$error("RAM clear held longer than one cycle");
		end

	// Written cell and character must be known
	lcdWriteKnown: assert property (@(posedge clk) disable iff (reset)
		lcd.write |-> !$isunknown(lcd.addr) && !$isunknown(lcd.data))
		else
		begin
			failCount++;
			$error("LCD write with an unknown cell or character");
		end

	// Menu text RAM is read only
	ramWriteLocal: assert property (@(posedge clk) disable iff (reset)
		ram.write |-> (ram.sel == selLocal))
		else
		begin
			failCount++;
			$error("RAM write not aimed at the local RAM");
		end

endmodule

//--- logic/lcdMenuTop.sv
`timescale 1ns/100ps

module lcdMenuTop #(
	parameter int lineLength = 16
) (
	input logic clk,
	input logic reset,
	input lcdMenuPkg::userInput_t userIn,
	input lcdMenuPkg::charCode_t ramRdData,
	output lcdMenuPkg::lcdWrite_t lcd,
	output lcdMenuPkg::ramPort_t ram
);
	import lcdMenuPkg::*;

	// Sequencer to copier
	copyJob_t job;
	logic copyStart;
	logic copyDone;
	lcdAddr_t copyRamAddr;
	lcdWrite_t copyLcd;

	// Sequencer RAM controls
	ramSel_t seqRamSel;
	menuText_t seqMenuSelect;
	logic seqClear;

	// Editor handshake
	logic editEnable;
	logic editSelecting;
	logic editReset;
	logic editCommit;
	lcdWrite_t editLcd;
	ramPort_t editRam;

	//////////////////////////////
	// Instances
	//////////////////////////////

	menuSequencer #(
		.lineLength(lineLength)
	) i_sequencer (
		.clk(clk),
		.reset(reset),
		.userIn(userIn),
		.copyDone(copyDone),
		.editCommit(editCommit),
		.job(job),
		.copyStart(copyStart),
		.ramSel(seqRamSel),
		.menuSelect(seqMenuSelect),
		.ramClear(seqClear),
		.editEnable(editEnable),
		.editSelecting(editSelecting),
		.editReset(editReset)
	);

	screenCopier #(
		.lineLength(lineLength)
	) i_copier (
		.clk(clk),
		.reset(reset),
		.job(job),
		.copyStart(copyStart),
		.ramRdData(ramRdData),
		.ramAddr(copyRamAddr),
		.lcdOut(copyLcd),
		.copyDone(copyDone)
	);

	charEditor i_editor (
		.clk(clk),
		.reset(reset),
		.userIn(userIn),
		.editEnable(editEnable),
		.editSelecting(editSelecting),
		.editReset(editReset),
		.lcdOut(editLcd),
		.ramWr(editRam),
		.editCommit(editCommit)
	);

	//////////////////////////////
	// Output muxes
	//////////////////////////////

	// Copier and editor never write in the same cycle
	assign lcd = copyLcd | editLcd;

	// Editor takes the address during a commit
	assign ram = '{
		sel: seqRamSel,
		menuSelect: seqMenuSelect,
		addr: editCommit ? editRam.addr : copyRamAddr,
		wrData: editRam.wrData,
		write: editRam.write,
		clear: seqClear
	};

endmodule

//--- logic/charEditor.sv
`timescale 1ns/100ps

module charEditor (
	input logic clk,
	input logic reset,
	input lcdMenuPkg::userInput_t userIn,
	input logic editEnable,
	input logic editSelecting,
	input logic editReset,
	output lcdMenuPkg::lcdWrite_t lcdOut,
	output lcdMenuPkg::ramPort_t ramWr,
	output logic editCommit
);
	import lcdMenuPkg::*;

	lcdAddr_t pos;
	logic [3:0] col;
	logic [3:0] row;
	charCode_t curChar;
	// Last character sent to the LCD
	charCode_t shownChar;
	lcdAddr_t wrAddr;
	charCode_t wrChar;
	logic commit;
	logic posPhase;
	logic charPhase;
	logic echo;

	// Columns 0-1 and 8-9 hold no printable glyphs
	function automatic logic [3:0] stepColumn(input logic [3:0] c, input logic left);
		if (left)
		begin
			case (c)
				4'd2: return 4'd15;
				4'd10: return 4'd7;
				default: return c - 4'd1;
			endcase
		end
		case (c)
			4'd7: return 4'd10;
			4'd15: return 4'd2;
			default: return c + 4'd1;
		endcase
	endfunction

	assign curChar = {col, row};
	assign posPhase = editEnable && !editSelecting;
	// Inputs ignored during the commit cycle
	assign charPhase = editEnable && editSelecting && !commit;
	assign echo = charPhase && (curChar != shownChar);

	//////////////////////////////
	// Position and character
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset || editReset)
		begin
			pos <= '0;
			col <= defaultChar[7:4];
			row <= defaultChar[3:0];
			shownChar <= defaultChar;
			commit <= 1'b0;
		end
		else
		begin
			commit <= 1'b0;
			if (echo)
				shownChar <= curChar;
			if (posPhase && userIn.rotaryEvent)
				pos <= userIn.rotaryLeft ? pos + 5'd1 : pos - 5'd1;
			else if (charPhase)
			begin
				if (userIn.rotaryBtn)
				begin
					// Write lands one cycle after the press
					commit <= 1'b1;
					wrAddr <= pos;
					wrChar <= curChar;
				end
				else if (userIn.rotaryEvent)
					row <= userIn.rotaryLeft ? row + 4'd1 : row - 4'd1;
				else if (userIn.colLeftBtn)
					col <= stepColumn(col, 1'b1);
				else if (userIn.colRightBtn)
					col <= stepColumn(col, 1'b0);
			end
		end
	end

	// Single echo of a changed character
	assign lcdOut = echo ? lcdWrite_t'{addr: pos, data: curChar, write: 1'b1}
		: lcdWrite_t'('0);

	assign ramWr = '{
		sel: selLocal,
		menuSelect: titleMain,
		addr: wrAddr,
		wrData: wrChar,
		write: commit,
		clear: 1'b0
	};
	assign editCommit = commit;

endmodule

//--- logic/screenCopier.sv
`timescale 1ns/100ps

module screenCopier #(
	parameter int lineLength = 16
) (
	input logic clk,
	input logic reset,
	input lcdMenuPkg::copyJob_t job,
	input logic copyStart,
	input lcdMenuPkg::charCode_t ramRdData,
	output lcdMenuPkg::lcdAddr_t ramAddr,
	output lcdMenuPkg::lcdWrite_t lcdOut,
	output logic copyDone
);
	import lcdMenuPkg::*;

	typedef enum logic [1:0] {
		cIdle,
		cSetup,
		cWrite,
		cDone
	} copyState_t;

	// Never run past the bottom right cell
	localparam lcdAddr_t lastCell = lcdAddr_t'(screenLines * lineLength - 1);

	copyState_t state;
	lcdAddr_t lcdAddr;
	lcdAddr_t stopAddr;
	logic lastWrite;

	assign lastWrite = (lcdAddr == stopAddr) || (lcdAddr == lastCell);

	//////////////////////////////
	// Setup/write pairs
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= cIdle;
			ramAddr <= '0;
		end
		else
		begin
			case (state)
				cIdle:
					if (copyStart)
					begin
						// Job latched here, sequencer is free to change it
						ramAddr <= '0;
						lcdAddr <= job.firstAddr;
						stopAddr <= job.lastAddr;
						state <= cSetup;
					end
				// RAM read settles
				cSetup:
					state <= cWrite;
				cWrite:
					if (lastWrite)
						state <= cDone;
					else
					begin
						ramAddr <= ramAddr + 5'd1;
						lcdAddr <= lcdAddr + 5'd1;
						state <= cSetup;
					end
				default:
					state <= cIdle;
			endcase
		end
	end

	// Zero when idle so the top can OR write ports
	assign lcdOut = (state == cWrite) ? lcdWrite_t'{addr: lcdAddr, data: ramRdData, write: 1'b1}
		: lcdWrite_t'('0);
	assign copyDone = (state == cDone);

endmodule

//--- logic/menuSequencer.sv
`timescale 1ns/100ps

module menuSequencer #(
	parameter int lineLength = 16
) (
	input logic clk,
	input logic reset,
	input lcdMenuPkg::userInput_t userIn,
	input logic copyDone,
	input logic editCommit,
	output lcdMenuPkg::copyJob_t job,
	output logic copyStart,
	output lcdMenuPkg::ramSel_t ramSel,
	output lcdMenuPkg::menuText_t menuSelect,
	output logic ramClear,
	output logic editEnable,
	output logic editSelecting,
	output logic editReset
);
	import lcdMenuPkg::*;

	typedef enum logic [2:0] {
		sTitle,
		sOption,
		sWaitCopy,
		sMenu,
		sShowLocal,
		sModifyPos,
		sModifyChar,
		sClear
	} seqState_t;

	// Line boundaries
	localparam lcdAddr_t lineOneLast = lcdAddr_t'(lineLength - 1);
	localparam lcdAddr_t lineTwoFirst = lcdAddr_t'(lineLength);
	localparam lcdAddr_t screenLast = lcdAddr_t'(screenLines * lineLength - 1);

	seqState_t state;
	// Where to go once the copier is done
	seqState_t nextState;
	menuText_t option;

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// Title shown above an option
	function automatic menuText_t titleOf(input menuText_t opt);
		if (opt == optYes || opt == optNo)
			return titleAreYouSure;
		return titleMain;
	endfunction

	// Left steps forward through the ring, right steps back
	function automatic menuText_t stepOption(input menuText_t opt, input logic left);
		case (opt)
			optDisplayLocal: return left ? optModifyLocal : optClearLocal;
			optModifyLocal: return left ? optClearLocal : optDisplayLocal;
			optClearLocal: return left ? optDisplayLocal : optModifyLocal;
			// Confirm screen just toggles
			optYes: return optNo;
			optNo: return optYes;
			default: return optDisplayLocal;
		endcase
	endfunction

	function automatic copyJob_t makeJob(input ramSel_t sel, input menuText_t text,
			input lcdAddr_t first, input lcdAddr_t last);
		copyJob_t j;
		j.ramSel = sel;
		j.menuSelect = text;
		j.firstAddr = first;
		j.lastAddr = last;
		return j;
	endfunction

	//////////////////////////////
	// Main FSM
	//////////////////////////////

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= sTitle;
			nextState <= sMenu;
			option <= optDisplayLocal;
			job <= makeJob(selMenu, titleMain, lineOneFirst, lineOneLast);
			copyStart <= 1'b0;
			editReset <= 1'b1;
		end
		else
		begin
			copyStart <= 1'b0;
			editReset <= userIn.menuBtn;
			if (userIn.menuBtn)
			begin
				option <= optDisplayLocal;
				// Let a running copy finish first
				if (state == sWaitCopy && !copyDone)
					nextState <= sTitle;
				else
					state <= sTitle;
			end
			else
			begin
				case (state)
					sTitle:
					begin
						job <= makeJob(selMenu, titleOf(option), lineOneFirst, lineOneLast);
						copyStart <= 1'b1;
						nextState <= sOption;
						state <= sWaitCopy;
					end
					sOption:
					begin
						job <= makeJob(selMenu, option, lineTwoFirst, screenLast);
						copyStart <= 1'b1;
						nextState <= sMenu;
						state <= sWaitCopy;
					end
					sWaitCopy:
						if (copyDone)
							state <= nextState;
					sMenu:
					begin
						if (userIn.rotaryBtn)
						begin
							case (option)
								optDisplayLocal, optModifyLocal:
								begin
									// Whole local RAM to the screen
									job <= makeJob(selLocal, option, lineOneFirst, screenLast);
									copyStart <= 1'b1;
									nextState <= (option == optDisplayLocal) ? sShowLocal : sModifyPos;
									state <= sWaitCopy;
								end
								optClearLocal:
								begin
									option <= optYes;
									state <= sTitle;
								end
								optYes:
									state <= sClear;
								default:
								begin
									option <= optDisplayLocal;
									state <= sTitle;
								end
							endcase
						end
						else if (userIn.rotaryEvent)
						begin
							option <= stepOption(option, userIn.rotaryLeft);
							state <= sTitle;
						end
					end
					sShowLocal:
						if (userIn.rotaryBtn)
							state <= sTitle;
					sModifyPos:
						if (userIn.rotaryBtn)
							state <= sModifyChar;
					// Editor owns the knob until it commits
					sModifyChar:
						if (editCommit)
							state <= sModifyPos;
					sClear:
					begin
						option <= optDisplayLocal;
						state <= sTitle;
					end
					default:
						state <= sTitle;
				endcase
			end
		end
	end

	// Clear always targets the local RAM
	assign ramSel = (state == sClear) ? selLocal : job.ramSel;
	assign menuSelect = job.menuSelect;
	assign ramClear = (state == sClear);

	// Editor phase flags
	assign editEnable = (state == sModifyPos) || (state == sModifyChar);
	assign editSelecting = (state == sModifyChar);

endmodule

//--- logic/lcdMenuPkg.sv
package lcdMenuPkg;

	//////////////////////////////
	// Basic types
	//////////////////////////////

	// Column in upper nibble, row in lower nibble
	typedef logic [7:0] charCode_t;

	// Cells 0-15 line one, 16-31 line two
	typedef logic [4:0] lcdAddr_t;

	// Screens held in the menu text RAM
	typedef enum logic [4:0] {
		titleMain,
		optDisplayLocal,
		optModifyLocal,
		optClearLocal,
		titleAreYouSure,
		optYes,
		optNo
	} menuText_t;

	// Which RAM the shared port talks to
	typedef enum logic {
		selMenu,
		selLocal
	} ramSel_t;

	//////////////////////////////
	// Port structs
	//////////////////////////////

	// Single-cycle pulses from the knob and buttons
	typedef struct packed {
		logic rotaryEvent;
		// Direction level, valid with rotaryEvent
		logic rotaryLeft;
		logic rotaryBtn;
		logic colLeftBtn;
		logic colRightBtn;
		logic menuBtn;
	} userInput_t;

	// One screen copy request
	typedef struct packed {
		ramSel_t ramSel;
		menuText_t menuSelect;
		lcdAddr_t firstAddr;
		lcdAddr_t lastAddr;
	} copyJob_t;

	// LCD write port, all zero when idle
	typedef struct packed {
		lcdAddr_t addr;
		charCode_t data;
		logic write;
	} lcdWrite_t;

	// Shared RAM port
	typedef struct packed {
		ramSel_t sel;
		menuText_t menuSelect;
		lcdAddr_t addr;
		charCode_t wrData;
		logic write;
		logic clear;
	} ramPort_t;

	//////////////////////////////
	// Constants
	//////////////////////////////

	// Letter A
	parameter charCode_t defaultChar = 8'h41;

	// Screen geometry
	parameter lcdAddr_t lineOneFirst = 5'd0;
	parameter int screenLines = 2;

endpackage
